// ==== rtl/minsel_config.svh ====
`ifndef MINSEL_CONFIG_SVH
`define MINSEL_CONFIG_SVH

// Channels per frame
// Also the number of samples grouped into one frame
`define MINSEL_NUM_CH 4

// Sample width in bits
`define MINSEL_DATA_W 8

// Frame tag width in bits
// Tags wrap at this width
`define MINSEL_TAG_W 8

// Frame buffer depth in whole frames
`define MINSEL_FIFO_DEPTH 4

`endif

// ==== rtl/minsel_pkg.sv ====
package minsel_pkg;

  `include "minsel_config.svh"

  // Width of a channel index within a frame
  localparam int CH_IDX_W = $clog2(`MINSEL_NUM_CH);

  // One sample of the stream
  typedef logic [`MINSEL_DATA_W-1:0] sample_t;

  // Frame as pushed into the buffer
  // Channel 0 holds the first sample received
  typedef struct packed {
    logic [`MINSEL_TAG_W-1:0]   tag;
    sample_t [`MINSEL_NUM_CH-1:0] samples;
  } frame_t;

  // Result of reducing one frame
  // Channel index is the lowest one holding the minimum
  typedef struct packed {
    logic [`MINSEL_TAG_W-1:0] tag;
    sample_t                  min_val;
    logic [CH_IDX_W-1:0]      ch_idx;
  } result_t;

endpackage

// ==== rtl/least_filter.sv ====
`timescale 1ns/10ps

module least_filter #(
  parameter int NUM_DATA   = 2,
  parameter int DATA_W     = 8,
  // Derived from NUM_DATA, keep the default
  parameter int DATA_IDX_W = $clog2(NUM_DATA)
) (
  input  logic [NUM_DATA-1:0][DATA_W-1:0] data_i,
  output logic [DATA_W-1:0]               data_o,
  output logic [DATA_IDX_W-1:0]           data_idx_o
);

  // Running minimum after each stage of the chain
  logic [DATA_W-1:0]     min_c [NUM_DATA];
  // Index that goes with the running minimum
  logic [DATA_IDX_W-1:0] idx_c [NUM_DATA];

  // First input seeds the chain
  assign min_c[0] = data_i[0];
  assign idx_c[0] = '0;

  for (genvar i = 1; i < NUM_DATA; i++)
  begin : gen_cmp
    logic take_c;

    // Replace only on strictly smaller
    // so on a tie the earlier index stays
    assign take_c = data_i[i] < min_c[i-1];

    assign min_c[i] = take_c ? data_i[i] : min_c[i-1];
    assign idx_c[i] = take_c ? DATA_IDX_W'(i) : idx_c[i-1];
  end

  // Last stage holds the overall winner
  assign data_o     = min_c[NUM_DATA-1];
  assign data_idx_o = idx_c[NUM_DATA-1];

endmodule

// ==== rtl/frame_assembler.sv ====
`timescale 1ns/10ps
`include "minsel_config.svh"

module frame_assembler (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                sample_valid_i,
  input  minsel_pkg::sample_t sample_i,
  output logic                frame_valid_o,
  output minsel_pkg::frame_t  frame_o
);

  import minsel_pkg::*;

  // Slot for the next accepted sample
  logic [CH_IDX_W-1:0] ch_cnt_q;
  // Tag for the next completed frame
  logic [`MINSEL_TAG_W-1:0] tag_cnt_q;
  // Samples gathered so far in this frame
  sample_t [`MINSEL_NUM_CH-1:0] collect_q;
  // Collected samples plus the completing one
  sample_t [`MINSEL_NUM_CH-1:0] assembled_c;
  logic last_c;
  logic frame_valid_q;
  frame_t frame_q;

  // Completing sample lands in the top slot
  assign last_c = sample_valid_i && (ch_cnt_q == CH_IDX_W'(`MINSEL_NUM_CH - 1));

  always_comb
  begin
    assembled_c = collect_q;
    assembled_c[`MINSEL_NUM_CH-1] = sample_i;
  end

  // Counters and strobe
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      ch_cnt_q      <= '0;
      tag_cnt_q     <= '0;
      frame_valid_q <= 1'b0;
    end
    else
    begin
      frame_valid_q <= last_c;
      if (last_c)
      begin
        // Tag advances even if the buffer later drops the frame
        ch_cnt_q  <= '0;
        tag_cnt_q <= tag_cnt_q + 1'b1;
      end
      else if (sample_valid_i)
      begin
        ch_cnt_q <= ch_cnt_q + 1'b1;
      end
    end
  end

  // Sample slots and outgoing frame
  always_ff @(posedge clk)
  begin
    if (sample_valid_i)
    begin
      collect_q[ch_cnt_q] <= sample_i;
    end
    if (last_c)
    begin
      frame_q.tag     <= tag_cnt_q;
      frame_q.samples <= assembled_c;
    end
  end

  assign frame_valid_o = frame_valid_q;
  assign frame_o       = frame_q;

endmodule

// ==== rtl/frame_fifo.sv ====
`timescale 1ns/10ps

module frame_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     empty_o,
  output logic     full_o,
  output logic     overflow_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Frame storage
  payload_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // Frames currently held
  logic [CNT_W-1:0] count_q;
  logic overflow_q;
  logic push_ok_c;
  logic pop_ok_c;

  // Pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  // Push while full is lost, even alongside a pop
  assign push_ok_c = push_i && !full_o;
  // Stray pop on empty does nothing
  assign pop_ok_c  = pop_i && !empty_o;

  always_ff @(posedge clk)
  begin
    if (push_ok_c)
    begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers, occupancy, overflow
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end
    else
    begin
      if (push_ok_c)
      begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_ok_c)
      begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      unique case ({push_ok_c, pop_ok_c})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Sticky until reset
      if (push_i && full_o)
      begin
        overflow_q <= 1'b1;
      end
    end
  end

  // Oldest frame, meaningful only while not empty
  assign head_o     = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

// ==== rtl/min_selector.sv ====
`timescale 1ns/10ps
`include "minsel_config.svh"

module min_selector (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                hold_i,
  input  logic                empty_i,
  input  minsel_pkg::frame_t  head_i,
  output logic                pop_o,
  output logic                result_valid_o,
  output minsel_pkg::result_t result_o
);

  import minsel_pkg::*;

  // Minimum of the head frame and its channel
  sample_t             min_c;
  logic [CH_IDX_W-1:0] idx_c;
  logic                result_valid_q;
  result_t             result_q;

  // Take the head whenever one is there and downstream allows
  // Pops can repeat every cycle
  assign pop_o = !empty_i && !hold_i;

  least_filter #(
    .NUM_DATA (`MINSEL_NUM_CH),
    .DATA_W   (`MINSEL_DATA_W)
  ) u_least_filter (
    .data_i     (head_i.samples),
    .data_o     (min_c),
    .data_idx_o (idx_c)
  );

  // Result strobe one cycle after the pop
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      result_valid_q <= 1'b0;
    end
    else
    begin
      result_valid_q <= pop_o;
    end
  end

  // Capture tag and reduction on the popping cycle
  always_ff @(posedge clk)
  begin
    if (pop_o)
    begin
      result_q.tag     <= head_i.tag;
      result_q.min_val <= min_c;
      result_q.ch_idx  <= idx_c;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

// ==== rtl/minsel_top.sv ====
`timescale 1ns/10ps
`include "minsel_config.svh"

module minsel_top (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                sample_valid_i,
  input  minsel_pkg::sample_t sample_i,
  input  logic                hold_i,
  output logic                result_valid_o,
  output minsel_pkg::result_t result_o,
  output logic                overflow_o,
  output logic                fifo_full_o
);

  import minsel_pkg::*;

  // Producer to buffer
  frame_t asm_frame;
  logic   asm_valid;

  // Buffer to consumer
  frame_t fifo_head;
  logic   fifo_empty;
  logic   fifo_pop;

  // Groups samples into tagged frames
  frame_assembler u_frame_assembler (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .frame_valid_o  (asm_valid),
    .frame_o        (asm_frame)
  );

  // Whole-frame queue, drops on full
  frame_fifo #(
    .payload_t (frame_t),
    .DEPTH     (`MINSEL_FIFO_DEPTH)
  ) u_frame_fifo (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .push_i     (asm_valid),
    .data_i     (asm_frame),
    .pop_i      (fifo_pop),
    .head_o     (fifo_head),
    .empty_o    (fifo_empty),
    .full_o     (fifo_full_o),
    .overflow_o (overflow_o)
  );

  // Pops frames and reports the minimum
  min_selector u_min_selector (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .hold_i         (hold_i),
    .empty_i        (fifo_empty),
    .head_i         (fifo_head),
    .pop_o          (fifo_pop),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

// ==== tb/minsel_asserts.sv ====
`timescale 1ns/10ps

module minsel_asserts (
  input logic clk,
  input logic rst_n_i,
  input logic pop_i,
  input logic empty_i,
  input logic overflow_i,
  input logic result_valid_i
);

  // Consumer takes only a frame that is there
  no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    pop_i |-> !empty_i
  )
  else $error("pop issued while the frame buffer was empty");

  // Sticky until the next reset
  overflow_stays_high: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    overflow_i |=> overflow_i
  )
  else $error("overflow flag fell without a reset");

  // Every popped frame gives a result one cycle later
  pop_gives_result: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    pop_i |=> result_valid_i
  )
  else $error("pop was not followed by a result strobe");

endmodule

// ==== tb/minsel_tb.sv ====
`timescale 1ns/10ps
`include "minsel_config.svh"

module minsel_tb;

  import minsel_pkg::*;

  localparam int NUM_CH = `MINSEL_NUM_CH;
  localparam int TAG_W  = `MINSEL_TAG_W;
  localparam logic [31:0] LFSR_SEED = 32'h3316_44c4;
  // x^32 + x^22 + x^2 + x + 1, right-shifting form
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  localparam int RST_CYCLES   = 10;
  localparam int N_RAND       = 16;
  localparam int N_TIE_DIR    = 5;
  localparam int N_TIE_RAND   = 8;
  localparam int N_EXTREME    = 5;
  localparam int N_SPARSE     = 12;
  localparam int N_HOLD       = 10;
  localparam int N_AFTER      = 6;
  localparam int TOTAL_FRAMES = N_RAND + N_TIE_DIR + N_TIE_RAND + N_EXTREME
                                + N_SPARSE + N_HOLD + N_AFTER;
  // Worst case 8 cycles per sample with gaps, plus drain slack
  localparam int STIM_CYCLES  = RST_CYCLES + TOTAL_FRAMES * NUM_CH * 8 + 200;
  localparam int WATCHDOG_CYC = STIM_CYCLES * 4;

  logic    clk;
  logic    rst_n_i;
  logic    sample_valid_i;
  sample_t sample_i;
  logic    hold_i;
  logic    result_valid_o;
  result_t result_o;
  logic    overflow_o;
  logic    fifo_full_o;

  logic [31:0] lfsr_q;
  // Random hold bursts, only while enabled
  logic        hold_rand_en;
  int          hold_left;

  // Frame being gathered on the stimulus side
  sample_t [NUM_CH-1:0] cur_frame;
  int                   cur_cnt;
  logic [TAG_W-1:0]     next_tag;
  // Recorded frames by tag, and tags still waiting for a result
  sample_t [NUM_CH-1:0] exp_frames [256];
  logic [TAG_W-1:0]     tag_q [$];
  int frames_sent;
  int results_seen;
  int drops_seen;

  minsel_top DUT (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .hold_i         (hold_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .overflow_o     (overflow_o),
    .fifo_full_o    (fifo_full_o)
  );

  // Buffer and result protocol checks
  bind minsel_top minsel_asserts u_minsel_asserts (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .pop_i          (fifo_pop),
    .empty_i        (fifo_empty),
    .overflow_i     (overflow_o),
    .result_valid_i (result_valid_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // Minimum of a frame, lowest channel wins a tie
  function automatic result_t expected_result(input logic [TAG_W-1:0] tag,
                                              input sample_t [NUM_CH-1:0] s);
    result_t r;
    r.tag     = tag;
    r.min_val = s[0];
    r.ch_idx  = '0;
    for (int c = 1; c < NUM_CH; c++)
    begin
      if (s[c] < r.min_val)
      begin
        r.min_val = s[c];
        r.ch_idx  = CH_IDX_W'(c);
      end
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_level(input string name, input logic got, input logic exp_v);
    assert (got === exp_v)
    else
    begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp_v);
      abort_run();
    end
  endtask

  task automatic update_hold();
    logic [31:0] r;
    if (hold_rand_en)
    begin
      if (hold_left > 0)
      begin
        hold_left--;
      end
      else
      begin
        // Roughly one burst start in eight cycles, 1 to 4 cycles long
        take_bits(3, r);
        if (r[2:0] == 3'd0)
        begin
          take_bits(2, r);
          hold_left = int'(r[1:0]) + 1;
        end
      end
      hold_i = (hold_left > 0);
    end
  endtask

  // Frames counted by accepted samples, gaps ignored
  task automatic record_sample(input sample_t v);
    cur_frame[cur_cnt] = v;
    cur_cnt++;
    if (cur_cnt == NUM_CH)
    begin
      exp_frames[next_tag] = cur_frame;
      tag_q.push_back(next_tag);
      next_tag = next_tag + 1'b1;
      frames_sent++;
      cur_cnt = 0;
    end
  endtask

  task automatic drive_sample(input sample_t v, input int gap);
    for (int g = 0; g < gap; g++)
    begin
      @(negedge clk);
      sample_valid_i = 1'b0;
      update_hold();
    end
    @(negedge clk);
    sample_valid_i = 1'b1;
    sample_i       = v;
    update_hold();
    record_sample(v);
  endtask

  // Channel 0 goes first
  task automatic send4(input sample_t c0, input sample_t c1,
                       input sample_t c2, input sample_t c3);
    drive_sample(c0, 0);
    drive_sample(c1, 0);
    drive_sample(c2, 0);
    drive_sample(c3, 0);
  endtask

  task automatic send_random_frame(input int val_bits, input sample_t base,
                                   input logic sparse);
    logic [31:0] r;
    int gap;
    for (int c = 0; c < NUM_CH; c++)
    begin
      gap = 0;
      if (sparse)
      begin
        take_bits(3, r);
        gap = int'(r[2:0]);
      end
      take_bits(val_bits, r);
      drive_sample(base + sample_t'(r), gap);
    end
  endtask

  // Stop input, release hold, wait until every frame is accounted for
  task automatic wait_drain();
    @(negedge clk);
    sample_valid_i = 1'b0;
    hold_rand_en   = 1'b0;
    hold_left      = 0;
    hold_i         = 1'b0;
    while (tag_q.size() != 0)
    begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic check_result(input result_t got);
    result_t          exp_r;
    logic [TAG_W-1:0] first_tag;
    int               skipped;
    skipped = 0;
    assert (tag_q.size() > 0)
    else
    begin
      $display("result with tag %h arrived while no frame was outstanding", got.tag);
      abort_run();
    end
    first_tag = tag_q[0];
    // Frames passed over here were dropped by the buffer
    while (tag_q.size() > 0 && tag_q[0] != got.tag)
    begin
      void'(tag_q.pop_front());
      skipped++;
    end
    assert (tag_q.size() > 0 && (skipped == 0 || overflow_o))
    else
    begin
      $display("[ERROR] result_o.tag: got %h expected %h", got.tag, first_tag);
      abort_run();
    end
    void'(tag_q.pop_front());
    drops_seen   += skipped;
    results_seen += 1;
    exp_r = expected_result(got.tag, exp_frames[got.tag]);
    assert (got.min_val == exp_r.min_val)
    else
    begin
      $display("[ERROR] result_o.min_val: got %h expected %h (tag %h)",
               got.min_val, exp_r.min_val, got.tag);
      abort_run();
    end
    assert (got.ch_idx == exp_r.ch_idx)
    else
    begin
      $display("[ERROR] result_o.ch_idx: got %h expected %h (tag %h)",
               got.ch_idx, exp_r.ch_idx, got.tag);
      abort_run();
    end
  endtask

  // Outputs settle after the rising edge, compare on the falling one
  always @(negedge clk)
  begin
    if (rst_n_i && result_valid_o)
    begin
      check_result(result_o);
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired with %0d frames still waiting for a result", tag_q.size());
    abort_run();
  end

  initial
  begin
    rst_n_i        = 1'b0;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    hold_i         = 1'b0;
    lfsr_q         = LFSR_SEED;
    hold_rand_en   = 1'b0;
    hold_left      = 0;
    cur_frame      = '0;
    cur_cnt        = 0;
    next_tag       = '0;
    frames_sent    = 0;
    results_seen   = 0;
    drops_seen     = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    check_level("result_valid_o", result_valid_o, 1'b0);
    check_level("overflow_o", overflow_o, 1'b0);
    check_level("fifo_full_o", fifo_full_o, 1'b0);

    // Back-to-back random frames, no hold
    for (int f = 0; f < N_RAND; f++)
    begin
      send_random_frame(8, 8'h00, 1'b0);
    end
    wait_drain();

    // Repeated minimum values
    send4(8'h55, 8'h55, 8'h55, 8'h55);
    send4(8'h09, 8'h03, 8'h03, 8'h07);
    send4(8'h08, 8'h06, 8'h02, 8'h02);
    send4(8'h04, 8'h04, 8'h06, 8'h04);
    send4(8'h07, 8'h05, 8'h09, 8'h05);
    // Narrow value range makes ties frequent
    for (int f = 0; f < N_TIE_RAND; f++)
    begin
      send_random_frame(2, 8'h40, 1'b0);
    end
    wait_drain();

    // Extremes of the sample range
    send4(8'h00, 8'h00, 8'h00, 8'h00);
    send4(8'hFF, 8'hFF, 8'hFF, 8'hFF);
    send4(8'hFF, 8'hFF, 8'hFF, 8'h00);
    send4(8'h00, 8'hFF, 8'hFF, 8'hFF);
    send4(8'hFF, 8'h00, 8'hFF, 8'h00);
    wait_drain();

    // Sparse samples with short hold bursts
    hold_rand_en = 1'b1;
    for (int f = 0; f < N_SPARSE; f++)
    begin
      send_random_frame(8, 8'h00, 1'b1);
    end
    wait_drain();

    // Long hold fills the buffer and later frames are lost
    @(negedge clk);
    hold_i = 1'b1;
    for (int f = 0; f < N_HOLD; f++)
    begin
      send_random_frame(8, 8'h00, 1'b0);
    end
    @(negedge clk);
    sample_valid_i = 1'b0;
    repeat (3) @(negedge clk);
    check_level("fifo_full_o", fifo_full_o, 1'b1);
    check_level("overflow_o", overflow_o, 1'b1);
    hold_i = 1'b0;
    for (int f = 0; f < N_AFTER; f++)
    begin
      send_random_frame(8, 8'h00, 1'b0);
    end
    wait_drain();
    check_level("overflow_o", overflow_o, 1'b1);
    assert (drops_seen > 0)
    else
    begin
      $display("hold burst ended without any dropped frame showing in the tags");
      abort_run();
    end

    repeat (10) @(negedge clk);
    assert (frames_sent == results_seen + drops_seen)
    else
    begin
      $display("%0d frames sent but %0d results and %0d drops seen",
               frames_sent, results_seen, drops_seen);
      abort_run();
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== minsel_top.f ====
+incdir+rtl
rtl/minsel_pkg.sv
rtl/least_filter.sv
rtl/frame_assembler.sv
rtl/frame_fifo.sv
rtl/min_selector.sv
rtl/minsel_top.sv
tb/minsel_asserts.sv
tb/minsel_tb.sv

// ==== Makefile ====
# Verilator build and run of the minsel testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module minsel_tb \
		-f minsel_top.f -o minsel_sim
	./obj_dir/minsel_sim | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
